//--- Makefile
TOP   = tb_muldiv
BUILD = obj_dir
LOG   = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module $(TOP) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- include/muldiv_defines.svh
`ifndef MULDIV_DEFINES_SVH
`define MULDIV_DEFINES_SVH

// ---------------------------------------------------------------------------
// datapath widths
// ---------------------------------------------------------------------------

// operand and result word
`define MULDIV_XLEN 64

// transaction tag carried alongside every request
`define MULDIV_TAG_W 3

// divider pre-shift count
// must reach XLEN itself for a zero divisor
`define MULDIV_SHIFT_W 7

`endif

//--- rtl/lead_one_finder.sv
`timescale 1ns/1ps
`include "muldiv_defines.svh"

module lead_one_finder #(
    parameter int unsigned WIDTH = `MULDIV_XLEN
) (
    input  logic [WIDTH-1:0]         bits_i,
    output logic [$clog2(WIDTH)-1:0] index_o,
    output logic                     none_o
);

    localparam int unsigned IDX_W = $clog2(WIDTH);
    // heap of 2*WIDTH-1 nodes, leaves in the upper WIDTH slots
    localparam int unsigned NODES = 2 * WIDTH - 1;

    // tree only balances for a power of two
    if ((WIDTH < 2) || (WIDTH != (1 << IDX_W))) begin : g_bad_width
        $error("lead_one_finder WIDTH must be a power of two, at least 2");
    end

    logic [NODES-1:0]            sel_nodes;
    logic [NODES-1:0][IDX_W-1:0] idx_nodes;

    // -------------------------------------------------------------------------
    // select tree
    // -------------------------------------------------------------------------
    always_comb begin
        sel_nodes = '0;
        idx_nodes = '0;

        // leaf i sees bit i, ordered so the left child covers lower bits
        for (int unsigned i = 0; i < WIDTH; i++) begin
            sel_nodes[WIDTH-1+i] = bits_i[i];
            idx_nodes[WIDTH-1+i] = IDX_W'(i);
        end

        // walk up from the last inner node to the root
        for (int n = int'(WIDTH) - 2; n >= 0; n--) begin
            sel_nodes[n] = sel_nodes[2*n+1] | sel_nodes[2*n+2];
            // lower half wins when both sides hold a one
            idx_nodes[n] = sel_nodes[2*n+1] ? idx_nodes[2*n+1] : idx_nodes[2*n+2];
        end
    end

    // root carries the answer
    assign index_o = idx_nodes[0];
    // no leaf was set
    assign none_o  = ~sel_nodes[0];

endmodule

//--- rtl/mul_pipe.sv
`timescale 1ns/1ps
`include "muldiv_defines.svh"

module mul_pipe (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   valid_i,
    input  muldiv_pkg::muldiv_op_e op_i,
    input  muldiv_pkg::tag_t       tag_i,
    input  muldiv_pkg::xlen_t      operand_a_i,
    input  muldiv_pkg::xlen_t      operand_b_i,
    output logic                   valid_o,
    output muldiv_pkg::tag_t       tag_o,
    output muldiv_pkg::xlen_t      result_o
);

    localparam int unsigned XLEN = `MULDIV_XLEN;

    // sign extension select per operand
    logic sign_a;
    logic sign_b;

    // 65x65 signed product, top two bits are pure sign
    logic signed [2*XLEN+1:0] product;
    logic                     take_high;

    logic              valid_q;
    muldiv_pkg::tag_t  tag_q;
    muldiv_pkg::xlen_t result_q;

    // -------------------------------------------------------------------------
    // operand signs
    // -------------------------------------------------------------------------
    always_comb begin
        sign_a = 1'b0;
        sign_b = 1'b0;
        case (op_i)
            // both signed
            muldiv_pkg::MULH: begin
                sign_a = 1'b1;
                sign_b = 1'b1;
            end
            // signed a times unsigned b
            muldiv_pkg::MULHSU: begin
                sign_a = 1'b1;
            end
            // MUL low half is sign agnostic, MULHU unsigned
            default: begin
                sign_a = 1'b0;
                sign_b = 1'b0;
            end
        endcase
    end

    // extra top bit turns every case into one signed multiply
    assign product = $signed({operand_a_i[XLEN-1] & sign_a, operand_a_i})
                   * $signed({operand_b_i[XLEN-1] & sign_b, operand_b_i});

    // everything but MUL wants the upper word
    assign take_high = (op_i != muldiv_pkg::MUL);

    // -------------------------------------------------------------------------
    // output register
    // -------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_i;
        end
    end

    // payload only moves with a request
    always_ff @(posedge clk_i) begin
        if (valid_i) begin
            tag_q    <= tag_i;
            result_q <= take_high ? product[2*XLEN-1:XLEN] : product[XLEN-1:0];
        end
    end

    assign valid_o  = valid_q;
    assign tag_o    = tag_q;
    assign result_o = result_q;

endmodule

//--- rtl/muldiv_pkg.sv
`include "muldiv_defines.svh"

package muldiv_pkg;

    // operand / result word
    typedef logic [`MULDIV_XLEN-1:0] xlen_t;

    // tag returned unchanged with the result
    typedef logic [`MULDIV_TAG_W-1:0] tag_t;

    // divider pre-shift and iteration count
    typedef logic [`MULDIV_SHIFT_W-1:0] shift_t;

    // operation select
    // low half of the encoding is the multiplier, high half the divider
    typedef enum logic [2:0] {
        MUL    = 3'd0,
        MULH   = 3'd1,
        MULHU  = 3'd2,
        MULHSU = 3'd3,
        DIV    = 3'd4,
        DIVU   = 3'd5,
        REM    = 3'd6,
        REMU   = 3'd7
    } muldiv_op_e;

    // serial divider FSM
    typedef enum logic [1:0] {
        DIV_IDLE = 2'd0,
        DIV_BUSY = 2'd1,
        DIV_DONE = 2'd2
    } div_state_e;

endpackage

//--- rtl/muldiv_top.sv
`timescale 1ns/1ps
`include "muldiv_defines.svh"

module muldiv_top (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   valid_i,
    input  muldiv_pkg::muldiv_op_e op_i,
    input  muldiv_pkg::tag_t       tag_i,
    input  muldiv_pkg::xlen_t      operand_a_i,
    input  muldiv_pkg::xlen_t      operand_b_i,
    output logic                   ready_o,
    output logic                   valid_o,
    output muldiv_pkg::tag_t       tag_o,
    output muldiv_pkg::xlen_t      result_o
);

    localparam int unsigned XLEN  = `MULDIV_XLEN;
    localparam int unsigned IDX_W = $clog2(XLEN);

    // request split
    logic is_div;
    logic mul_valid;
    logic div_valid;

    // multiplier side
    logic              mul_out_valid;
    muldiv_pkg::tag_t  mul_tag;
    muldiv_pkg::xlen_t mul_result;

    // divider operand prep
    logic               div_signed;
    logic               div_rem;
    logic               divisor_neg;
    logic               divisor_zero;
    muldiv_pkg::xlen_t  divisor_rev;
    muldiv_pkg::xlen_t  lof_input;
    logic [IDX_W-1:0]   lof_index;
    logic               lof_none;
    muldiv_pkg::shift_t div_shift;
    muldiv_pkg::xlen_t  divisor_shifted;

    // divider side
    logic              div_out_valid;
    logic              div_out_ready;
    muldiv_pkg::tag_t  div_tag;
    muldiv_pkg::xlen_t div_result;

    // -------------------------------------------------------------------------
    // decode
    // -------------------------------------------------------------------------
    assign is_div    = op_i inside {muldiv_pkg::DIV, muldiv_pkg::DIVU,
                                    muldiv_pkg::REM, muldiv_pkg::REMU};
    assign mul_valid = valid_i & ~is_div;
    assign div_valid = valid_i & is_div;

    assign div_signed = op_i inside {muldiv_pkg::DIV, muldiv_pkg::REM};
    assign div_rem    = op_i inside {muldiv_pkg::REM, muldiv_pkg::REMU};

    // -------------------------------------------------------------------------
    // multiplier
    // -------------------------------------------------------------------------
    mul_pipe mul_pipe_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .valid_i     (mul_valid),
        .op_i        (op_i),
        .tag_i       (tag_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .valid_o     (mul_out_valid),
        .tag_o       (mul_tag),
        .result_o    (mul_result)
    );

    // -------------------------------------------------------------------------
    // divisor normalisation
    // -------------------------------------------------------------------------

    // sign only counts for signed ops
    assign divisor_neg  = div_signed & operand_b_i[XLEN-1];
    assign divisor_zero = ~(|operand_b_i);

    // reversed, so the first one from the low end is the top of the divisor
    assign divisor_rev = {<<{operand_b_i}};
    // negative divisor: count leading ones instead
    assign lof_input   = divisor_neg ? ~divisor_rev : divisor_rev;

    lead_one_finder #(
        .WIDTH (XLEN)
    ) lead_one_finder_i (
        .bits_i  (lof_input),
        .index_o (lof_index),
        .none_o  (lof_none)
    );

    // nothing found means full width
    assign div_shift       = lof_none ? muldiv_pkg::shift_t'(XLEN)
                                      : muldiv_pkg::shift_t'(lof_index);
    assign divisor_shifted = operand_b_i << div_shift;

    // -------------------------------------------------------------------------
    // divider
    // -------------------------------------------------------------------------
    serial_divider serial_divider_i (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .in_valid_i        (div_valid),
        .tag_i             (tag_i),
        .dividend_i        (operand_a_i),
        .divisor_shifted_i (divisor_shifted),
        .shift_i           (div_shift),
        .divisor_zero_i    (divisor_zero),
        .divisor_neg_i     (divisor_neg),
        .signed_i          (div_signed),
        .rem_i             (div_rem),
        .out_ready_i       (div_out_ready),
        .in_ready_o        (ready_o),
        .out_valid_o       (div_out_valid),
        .tag_o             (div_tag),
        .result_o          (div_result)
    );

    // -------------------------------------------------------------------------
    // result port
    // -------------------------------------------------------------------------

    // multiplier has no stall, so it always wins
    assign div_out_ready = ~mul_out_valid;
    assign valid_o       = mul_out_valid | div_out_valid;
    assign tag_o         = mul_out_valid ? mul_tag : div_tag;
    assign result_o      = mul_out_valid ? mul_result : div_result;

    // divide issued only while the divider is idle
    a_div_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
        div_valid |-> ready_o)
        else $error("divide request while ready_o is low");

endmodule

//--- rtl/serial_divider.sv
`timescale 1ns/1ps
`include "muldiv_defines.svh"

module serial_divider (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              in_valid_i,
    input  muldiv_pkg::tag_t   tag_i,
    input  muldiv_pkg::xlen_t  dividend_i,
    input  muldiv_pkg::xlen_t  divisor_shifted_i,
    input  muldiv_pkg::shift_t shift_i,
    input  logic              divisor_zero_i,
    input  logic              divisor_neg_i,
    input  logic              signed_i,
    input  logic              rem_i,
    input  logic              out_ready_i,
    output logic              in_ready_o,
    output logic              out_valid_o,
    output muldiv_pkg::tag_t   tag_o,
    output muldiv_pkg::xlen_t  result_o
);

    localparam int unsigned XLEN = `MULDIV_XLEN;

    muldiv_pkg::div_state_e state_q;
    muldiv_pkg::div_state_e state_d;

    // A holds the running remainder, B the shifted divisor
    muldiv_pkg::xlen_t a_q;
    muldiv_pkg::xlen_t b_q;
    // quotient bits enter from the top, so it ends up reversed
    muldiv_pkg::xlen_t quot_q;
    muldiv_pkg::tag_t  tag_q;

    muldiv_pkg::shift_t cnt_q;
    muldiv_pkg::shift_t cnt_d;
    logic               cnt_zero;

    // flags captured with the request
    logic rem_q;
    logic comp_inv_q;
    logic res_neg_q;
    logic zero_q;
    logic res_neg_d;

    // FSM controls
    logic load;
    logic a_en;
    logic b_en;
    logic quot_en;

    // datapath
    logic              ab_geq;
    logic              add_sel;
    muldiv_pkg::xlen_t add_lhs;
    muldiv_pkg::xlen_t add_rhs;
    muldiv_pkg::xlen_t add_out;
    muldiv_pkg::xlen_t b_next;
    muldiv_pkg::xlen_t quot_rev;
    muldiv_pkg::xlen_t out_sel;

    // -------------------------------------------------------------------------
    // datapath
    // -------------------------------------------------------------------------

    // on load the adder forms +a or -a
    // negate when a signed op has operands of opposite sign
    assign add_sel = load & ~(signed_i & (dividend_i[XLEN-1] ^ divisor_neg_i));
    assign add_lhs = load ? '0 : a_q;
    assign add_rhs = load ? dividend_i : b_q;
    assign add_out = add_sel ? (add_lhs + add_rhs) : (add_lhs - add_rhs);

    // B walks right, refilled with its sign for a negative divisor
    assign b_next = load ? divisor_shifted_i : {comp_inv_q, b_q[XLEN-1:1]};

    // |A| >= |B|
    // with a negative divisor both sit in the upper half, so the order flips
    // a zero remainder never subtracts, except for the zero divisor
    assign ab_geq = ((a_q == b_q) | ((a_q > b_q) ^ comp_inv_q)) & ((|a_q) | zero_q);

    assign quot_rev = {<<{quot_q}};
    assign out_sel  = rem_q ? a_q : quot_rev;
    // final sign fix
    assign result_o = res_neg_q ? -out_sel : out_sel;

    // negate only when signs differ
    // quotient of a zero divisor stays all ones
    assign res_neg_d = (~divisor_zero_i | rem_i) & signed_i
                     & (dividend_i[XLEN-1] ^ divisor_neg_i);

    // -------------------------------------------------------------------------
    // iteration counter
    // -------------------------------------------------------------------------
    assign cnt_zero = (cnt_q == '0);
    assign cnt_d    = load     ? shift_i :
                      cnt_zero ? cnt_q   : cnt_q - 1'b1;

    // -------------------------------------------------------------------------
    // FSM
    // -------------------------------------------------------------------------
    always_comb begin
        state_d     = state_q;
        in_ready_o  = 1'b0;
        out_valid_o = 1'b0;
        load        = 1'b0;
        a_en        = 1'b0;
        b_en        = 1'b0;
        quot_en     = 1'b0;

        case (state_q)
            muldiv_pkg::DIV_IDLE: begin
                in_ready_o = 1'b1;
                if (in_valid_i) begin
                    load    = 1'b1;
                    a_en    = 1'b1;
                    b_en    = 1'b1;
                    state_d = muldiv_pkg::DIV_BUSY;
                end
            end
            // shift+1 compare/subtract steps
            muldiv_pkg::DIV_BUSY: begin
                a_en    = ab_geq;
                b_en    = 1'b1;
                quot_en = 1'b1;
                if (cnt_zero) begin
                    state_d = muldiv_pkg::DIV_DONE;
                end
            end
            // hold until the port is free
            muldiv_pkg::DIV_DONE: begin
                out_valid_o = 1'b1;
                if (out_ready_i) begin
                    state_d = muldiv_pkg::DIV_IDLE;
                end
            end
            default: begin
                state_d = muldiv_pkg::DIV_IDLE;
            end
        endcase
    end

    // -------------------------------------------------------------------------
    // registers
    // -------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= muldiv_pkg::DIV_IDLE;
            cnt_q      <= '0;
            rem_q      <= 1'b0;
            comp_inv_q <= 1'b0;
            res_neg_q  <= 1'b0;
            zero_q     <= 1'b0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
            if (load) begin
                rem_q      <= rem_i;
                comp_inv_q <= divisor_neg_i;
                res_neg_q  <= res_neg_d;
                zero_q     <= divisor_zero_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (a_en) begin
            a_q <= add_out;
        end
        if (b_en) begin
            b_q <= b_next;
        end
        if (load) begin
            quot_q <= '0;
            tag_q  <= tag_i;
        end else if (quot_en) begin
            quot_q <= {ab_geq, quot_q[XLEN-1:1]};
        end
    end

    assign tag_o = tag_q;

    // -------------------------------------------------------------------------
    // assertions
    // -------------------------------------------------------------------------

    // upstream must wait for idle
    a_in_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        in_valid_i |-> (state_q == muldiv_pkg::DIV_IDLE))
        else $error("divider request outside DIV_IDLE");

    // stalled result stays put
    a_done_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ((state_q == muldiv_pkg::DIV_DONE) && !out_ready_i)
        |=> ((state_q == muldiv_pkg::DIV_DONE) && $stable(tag_o) && $stable(result_o)))
        else $error("divider result changed while waiting");

endmodule

//--- sources.f
+incdir+include
rtl/muldiv_pkg.sv
rtl/lead_one_finder.sv
rtl/mul_pipe.sv
rtl/serial_divider.sv
rtl/muldiv_top.sv
verification/tb_muldiv.sv

//--- verification/tb_muldiv.sv
`timescale 1ns/1ps
`include "muldiv_defines.svh"

module tb_muldiv;

    localparam int XLEN            = `MULDIV_XLEN;
    localparam int RESET_CYCLES    = 5;
    localparam int N_CORNER        = 6;
    localparam int N_RAND_MUL      = 32;
    localparam int N_RAND_DIV      = 16;
    localparam int N_RAND_SIGNED   = 12;
    localparam int N_SIGNED_FIXED  = 10;
    localparam int N_PRIO_MUL      = 24;
    // longest divide is a full pre-shift plus load and done
    localparam int DIV_MAX_CYCLES  = XLEN + 8;
    localparam int N_DIV_CALLS     = 2 * (N_RAND_DIV + 3 + N_SIGNED_FIXED + N_RAND_SIGNED);
    localparam int MUL_CYCLES      = 4 * N_CORNER * N_CORNER + N_RAND_MUL + 4;
    localparam int TIMEOUT_CYCLES  = RESET_CYCLES + MUL_CYCLES
                                   + N_DIV_CALLS * (DIV_MAX_CYCLES + 3)
                                   + N_PRIO_MUL + DIV_MAX_CYCLES + 100;

    logic                   clk;
    logic                   rst_n;
    logic                   valid;
    muldiv_pkg::muldiv_op_e op;
    muldiv_pkg::tag_t       tag;
    muldiv_pkg::xlen_t      operand_a;
    muldiv_pkg::xlen_t      operand_b;
    logic                   ready;
    logic                   valid_out;
    muldiv_pkg::tag_t       tag_out;
    muldiv_pkg::xlen_t      result;

    logic [63:0]       rng_state;
    int                errors;
    int                checks;
    int                cycle_cnt;
    int                div_seen;
    muldiv_pkg::tag_t  next_tag;

    // multiply issued last cycle, due at the port now
    logic              pend_valid;
    muldiv_pkg::tag_t  pend_tag;
    muldiv_pkg::xlen_t pend_result;

    muldiv_top muldiv_top_i (
        .clk_i       (clk),
        .rst_ni      (rst_n),
        .valid_i     (valid),
        .op_i        (op),
        .tag_i       (tag),
        .operand_a_i (operand_a),
        .operand_b_i (operand_b),
        .ready_o     (ready),
        .valid_o     (valid_out),
        .tag_o       (tag_out),
        .result_o    (result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // -------------------------------------------------------------------------
    // reference model
    // -------------------------------------------------------------------------

    // xorshift64
    function automatic logic [63:0] next_random();
        logic [63:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        rng_state = x;
        return x;
    endfunction

    function automatic muldiv_pkg::xlen_t expected_mul(input muldiv_pkg::muldiv_op_e m_op,
                                                       input muldiv_pkg::xlen_t a,
                                                       input muldiv_pkg::xlen_t b);
        logic [127:0] ea;
        logic [127:0] eb;
        logic [127:0] p;
        // a is signed for MULH and MULHSU, b only for MULH
        ea = (m_op == muldiv_pkg::MULH || m_op == muldiv_pkg::MULHSU)
           ? {{64{a[63]}}, a} : {64'd0, a};
        eb = (m_op == muldiv_pkg::MULH) ? {{64{b[63]}}, b} : {64'd0, b};
        p  = ea * eb;
        return (m_op == muldiv_pkg::MUL) ? p[63:0] : p[127:64];
    endfunction

    function automatic muldiv_pkg::xlen_t expected_div(input muldiv_pkg::muldiv_op_e d_op,
                                                       input muldiv_pkg::xlen_t a,
                                                       input muldiv_pkg::xlen_t b);
        logic               is_signed;
        logic               is_rem;
        logic signed [127:0] sa;
        logic signed [127:0] sb;
        logic signed [127:0] sq;
        logic signed [127:0] sr;
        muldiv_pkg::xlen_t  q;
        muldiv_pkg::xlen_t  r;
        is_signed = (d_op == muldiv_pkg::DIV) || (d_op == muldiv_pkg::REM);
        is_rem    = (d_op == muldiv_pkg::REM) || (d_op == muldiv_pkg::REMU);
        sa = is_signed ? {{64{a[63]}}, a} : {64'd0, a};
        sb = is_signed ? {{64{b[63]}}, b} : {64'd0, b};
        if (b == '0) begin
            // zero divisor: all ones and the dividend
            q = '1;
            r = a;
        end else if (is_signed && a == 64'h8000_0000_0000_0000 && b == '1) begin
            // signed overflow
            q = a;
            r = '0;
        end else begin
            // truncating division, remainder follows the dividend
            sq = sa / sb;
            sr = sa % sb;
            q  = sq[63:0];
            r  = sr[63:0];
        end
        return is_rem ? r : q;
    endfunction

    function automatic muldiv_pkg::xlen_t corner_value(input int idx);
        case (idx)
            0:       return 64'h0000_0000_0000_0000;
            1:       return 64'h0000_0000_0000_0001;
            2:       return 64'hffff_ffff_ffff_ffff;
            3:       return 64'h8000_0000_0000_0000;
            4:       return 64'h7fff_ffff_ffff_ffff;
            default: return 64'h0123_4567_89ab_cdef;
        endcase
    endfunction

    // -------------------------------------------------------------------------
    // drive and check helpers
    // -------------------------------------------------------------------------
    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error at %0t: %s expected %h, got %h", $realtime, name, expected, actual);
        end
    endtask

    task automatic drive_request(input muldiv_pkg::muldiv_op_e req_op,
                                 input muldiv_pkg::xlen_t a, input muldiv_pkg::xlen_t b,
                                 input muldiv_pkg::tag_t req_tag);
        valid     = 1'b1;
        op        = req_op;
        tag       = req_tag;
        operand_a = a;
        operand_b = b;
    endtask

    task automatic drive_idle();
        valid     = 1'b0;
        op        = muldiv_pkg::MUL;
        tag       = '0;
        operand_a = '0;
        operand_b = '0;
    endtask

    // port must show exactly the pending multiply, or nothing
    task automatic check_mul_output();
        if (pend_valid) begin
            check_value("valid_o", 64'd1, 64'(valid_out));
            check_value("tag_o", 64'(pend_tag), 64'(tag_out));
            check_value("result_o", pend_result, result);
        end else begin
            check_value("valid_o", 64'd0, 64'(valid_out));
        end
    endtask

    // one multiply per cycle, previous one checked first
    task automatic mul_step(input muldiv_pkg::muldiv_op_e m_op,
                            input muldiv_pkg::xlen_t a, input muldiv_pkg::xlen_t b);
        @(negedge clk);
        check_mul_output();
        drive_request(m_op, a, b, next_tag);
        pend_valid  = 1'b1;
        pend_tag    = next_tag;
        pend_result = expected_mul(m_op, a, b);
        next_tag++;
    endtask

    task automatic mul_flush();
        @(negedge clk);
        check_mul_output();
        drive_idle();
        pend_valid = 1'b0;
        @(negedge clk);
        check_mul_output();
    endtask

    task automatic run_div(input muldiv_pkg::muldiv_op_e d_op,
                           input muldiv_pkg::xlen_t a, input muldiv_pkg::xlen_t b);
        muldiv_pkg::xlen_t exp_result;
        muldiv_pkg::tag_t  div_tag;
        int                waited;
        exp_result = expected_div(d_op, a, b);
        div_tag    = next_tag;
        next_tag++;
        @(negedge clk);
        check_value("ready_o", 64'd1, 64'(ready));
        drive_request(d_op, a, b, div_tag);
        @(negedge clk);
        drive_idle();
        waited = 0;
        while (!valid_out && waited < DIV_MAX_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (!valid_out) begin
            errors++;
            $display("error at %0t: divide with tag %0d never returned a result",
                     $realtime, div_tag);
        end else begin
            check_value("tag_o", 64'(div_tag), 64'(tag_out));
            check_value("result_o", exp_result, result);
            // result leaves after one cycle, divider idle again
            @(negedge clk);
            check_value("valid_o", 64'd0, 64'(valid_out));
            check_value("ready_o", 64'd1, 64'(ready));
        end
    endtask

    task automatic div_signed_pair(input muldiv_pkg::xlen_t a, input muldiv_pkg::xlen_t b);
        run_div(muldiv_pkg::DIV, a, b);
        run_div(muldiv_pkg::REM, a, b);
    endtask

    // a valid_o without a pending multiply must be the divide
    task automatic observe_port(input muldiv_pkg::tag_t dtag, input muldiv_pkg::xlen_t dres);
        if (pend_valid) begin
            check_mul_output();
        end else if (valid_out) begin
            div_seen++;
            check_value("tag_o", 64'(dtag), 64'(tag_out));
            check_value("result_o", dres, result);
        end
    endtask

    // -------------------------------------------------------------------------
    // tests
    // -------------------------------------------------------------------------
    task automatic test_reset();
        @(negedge clk);
        check_value("valid_o", 64'd0, 64'(valid_out));
        check_value("ready_o", 64'd1, 64'(ready));
    endtask

    task automatic test_multiply();
        logic [63:0] r;
        // corner pairs, all four ops, back to back
        for (int i = 0; i < N_CORNER; i++) begin
            for (int j = 0; j < N_CORNER; j++) begin
                for (int k = 0; k < 4; k++) begin
                    mul_step(muldiv_pkg::muldiv_op_e'(3'(k)), corner_value(i), corner_value(j));
                end
            end
        end
        for (int n = 0; n < N_RAND_MUL; n++) begin
            r = next_random();
            mul_step(muldiv_pkg::muldiv_op_e'({1'b0, r[1:0]}), next_random(), next_random());
        end
        mul_flush();
    endtask

    task automatic test_unsigned_div();
        muldiv_pkg::xlen_t a;
        muldiv_pkg::xlen_t b;
        logic [63:0]       r;
        for (int n = 0; n < N_RAND_DIV; n++) begin
            a = next_random();
            r = next_random();
            // vary divisor length to vary the pre-shift
            b = next_random() >> r[5:0];
            run_div(muldiv_pkg::DIVU, a, b);
            run_div(muldiv_pkg::REMU, a, b);
        end
        a = next_random();
        run_div(muldiv_pkg::DIVU, a, '0);
        run_div(muldiv_pkg::REMU, a, '0);
        run_div(muldiv_pkg::DIVU, a, 64'd1);
        run_div(muldiv_pkg::REMU, a, 64'd1);
        // divisor larger than dividend
        run_div(muldiv_pkg::DIVU, 64'd5, a | 64'h8000_0000_0000_0000);
        run_div(muldiv_pkg::REMU, 64'd5, a | 64'h8000_0000_0000_0000);
    endtask

    task automatic test_signed_div();
        logic [63:0] r;
        muldiv_pkg::xlen_t b;
        // all sign combinations
        div_signed_pair(64'd100, 64'd7);
        div_signed_pair(-64'sd100, 64'd7);
        div_signed_pair(64'd100, -64'sd7);
        div_signed_pair(-64'sd100, -64'sd7);
        div_signed_pair(64'd5, -64'sd100);
        div_signed_pair(64'd0, -64'sd5);
        // overflow and its neighbour
        div_signed_pair(64'h8000_0000_0000_0000, 64'hffff_ffff_ffff_ffff);
        div_signed_pair(64'h8000_0000_0000_0000, 64'd1);
        // zero divisor, both dividend signs
        div_signed_pair(64'd123, '0);
        div_signed_pair(-64'sd123, '0);
        for (int n = 0; n < N_RAND_SIGNED; n++) begin
            r = next_random();
            b = muldiv_pkg::xlen_t'($signed(next_random()) >>> r[5:0]);
            div_signed_pair(next_random(), b);
        end
    endtask

    task automatic test_mul_priority();
        muldiv_pkg::xlen_t a;
        muldiv_pkg::xlen_t b;
        muldiv_pkg::xlen_t div_expected;
        muldiv_pkg::tag_t  div_tag;
        logic [63:0]       r;
        int                waited;
        // long divisor, short pre-shift, done well inside the stream
        a            = next_random();
        b            = next_random() | 64'h4000_0000_0000_0000;
        div_tag      = 3'd7;
        div_expected = expected_div(muldiv_pkg::DIVU, a, b);
        div_seen     = 0;
        @(negedge clk);
        check_value("ready_o", 64'd1, 64'(ready));
        drive_request(muldiv_pkg::DIVU, a, b, div_tag);
        pend_valid = 1'b0;
        for (int i = 0; i < N_PRIO_MUL; i++) begin
            @(negedge clk);
            observe_port(div_tag, div_expected);
            r = next_random();
            pend_tag = 3'(i % 7);
            drive_request(muldiv_pkg::muldiv_op_e'({1'b0, r[1:0]}), next_random(),
                          next_random(), pend_tag);
            pend_valid  = 1'b1;
            pend_result = expected_mul(op, operand_a, operand_b);
        end
        @(negedge clk);
        observe_port(div_tag, div_expected);
        drive_idle();
        pend_valid = 1'b0;
        waited     = 0;
        while (div_seen == 0 && waited < DIV_MAX_CYCLES) begin
            @(negedge clk);
            observe_port(div_tag, div_expected);
            waited++;
        end
        // catch a duplicate
        repeat (3) begin
            @(negedge clk);
            observe_port(div_tag, div_expected);
        end
        check_value("divide result count", 64'd1, 64'(div_seen));
        check_value("ready_o", 64'd1, 64'(ready));
    endtask

    // -------------------------------------------------------------------------
    // sequence and watchdog
    // -------------------------------------------------------------------------
    initial begin
        $timeformat(-9, 3, " ns", 0);
        rng_state  = 64'd58799;
        errors     = 0;
        checks     = 0;
        div_seen   = 0;
        next_tag   = '0;
        pend_valid = 1'b0;
        rst_n      = 1'b0;
        drive_idle();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        test_reset();
        test_multiply();
        test_unsigned_div();
        test_signed_div();
        test_mul_priority();

        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Verification failed");
        $finish;
    end

endmodule
